/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_isa_pkg.sv
  - source/cpu_ctrl_pkg.sv
  - source/pc_unit.sv
  - source/inst_mem.sv
  - source/decoder.sv
  - source/reg_file.sv
  - source/alu.sv
  - source/data_mem.sv
  - source/rv_core.sv
  - target: test
    files:
      - bench/tb_rv_core.sv

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core import rv_isa_pkg::*, cpu_ctrl_pkg::*; ();

	logic clk;
	logic arst_n;
	logic run;
	logic imem_we;
	logic [imem_depth_log2-1:0] imem_addr;
	logic [xlen-1:0] imem_wdata;
	logic retire_valid;
	retire_t retire;

	// instruction-set model state
	logic [31:0] prog [$];
	logic [31:0] model_imem [2**imem_depth_log2];
	logic [31:0] mregs [32];
	logic [7:0] mdmem [1024];
	logic [31:0] model_pc;
	int retire_count;
	logic [31:0] rng;
	retire_t expected;
	logic [31:0] expected_npc;

	rv_core dut0 (
		.clk, .arst_n, .run,
		.imem_we, .imem_addr, .imem_wdata,
		.retire_valid, .retire
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string what);
		stop_on_failure($sformatf("ERROR at %0t: %s", $time, what));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// instruction encoders for the program
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input int imm);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [4:0] rs1, input int imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input int off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	// lui plus addi, upper part rounded for the signed low part
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = (value + 32'h800) >> 12;
		prog.push_back(u_type(op_lui, rd, hi[19:0]));
		prog.push_back(i_type(op_imm, 3'b000, rd, rd, int'(value[11:0])));
	endtask

	task automatic build_program();
		logic [2:0] imm_f3 [5];
		imm_f3 = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
		// arithmetic
		for (int r = 1; r <= 8; r++) begin
			rng = xorshift(rng);
			load_const(5'(r), rng);
		end
		prog.push_back(r_type(7'h00, 2, 1, 3'b000, 9));
		prog.push_back(r_type(7'h20, 4, 3, 3'b000, 10));
		prog.push_back(r_type(7'h00, 6, 5, 3'b111, 11));
		prog.push_back(r_type(7'h00, 8, 7, 3'b110, 12));
		prog.push_back(r_type(7'h00, 1, 8, 3'b100, 13));
		prog.push_back(r_type(7'h00, 2, 1, 3'b010, 14));
		prog.push_back(r_type(7'h00, 1, 2, 3'b010, 15));
		for (int k = 0; k < 5; k++) begin
			rng = xorshift(rng);
			prog.push_back(i_type(op_imm, imm_f3[k], 5'(16 + k), 5'(1 + k), int'(rng[11:0])));
		end
		rng = xorshift(rng);
		prog.push_back(u_type(op_auipc, 21, rng[19:0]));
		// x0 write is computed but dropped
		prog.push_back(r_type(7'h00, 2, 1, 3'b000, 0));
		prog.push_back(r_type(7'h00, 3, 0, 3'b000, 22));
		prog.push_back(i_type(op_imm, 3'b000, 23, 0, 5));
		prog.push_back(32'hffff_ffff);
		// stores at every lane, then loads of every width
		load_const(19, 32'h80ff_7f01);
		prog.push_back(i_type(op_imm, 3'b000, 20, 0, 256));
		prog.push_back(s_type(3'b010, 1, 20, 0));
		prog.push_back(s_type(3'b010, 2, 20, 4));
		prog.push_back(s_type(3'b010, 3, 20, 8));
		prog.push_back(s_type(3'b010, 19, 20, 12));
		for (int k = 0; k < 4; k++) begin
			prog.push_back(s_type(3'b000, 5'(4 + k), 20, k));
		end
		prog.push_back(s_type(3'b001, 8, 20, 4));
		prog.push_back(s_type(3'b001, 9, 20, 6));
		for (int k = 0; k < 4; k++) begin
			prog.push_back(i_type(op_load, 3'b000, 5'(24 + k), 20, 12 + k));
			prog.push_back(i_type(op_load, 3'b100, 5'(28 + k), 20, 12 + k));
		end
		prog.push_back(i_type(op_load, 3'b001, 24, 20, 12));
		prog.push_back(i_type(op_load, 3'b001, 25, 20, 14));
		prog.push_back(i_type(op_load, 3'b101, 26, 20, 14));
		prog.push_back(i_type(op_load, 3'b101, 27, 20, 6));
		prog.push_back(i_type(op_load, 3'b010, 28, 20, 0));
		prog.push_back(i_type(op_load, 3'b010, 29, 20, 4));
		prog.push_back(i_type(op_load, 3'b010, 30, 20, 8));
		// countdown loop, then taken and untaken branches and jumps
		prog.push_back(i_type(op_imm, 3'b000, 10, 0, 3));
		prog.push_back(i_type(op_imm, 3'b000, 10, 10, -1));
		prog.push_back(b_type(3'b001, 10, 0, -4));
		prog.push_back(b_type(3'b000, 10, 0, 8));
		prog.push_back(i_type(op_imm, 3'b000, 11, 0, 1));
		prog.push_back(b_type(3'b000, 10, 23, 8));
		prog.push_back(b_type(3'b001, 10, 10, 8));
		prog.push_back(j_type(1, 8));
		prog.push_back(i_type(op_imm, 3'b000, 12, 0, 1));
		// odd jalr target, lands on the add
		prog.push_back(u_type(op_auipc, 13, 20'h0));
		prog.push_back(i_type(op_imm, 3'b000, 13, 13, 17));
		prog.push_back(i_type(op_jalr, 3'b000, 14, 13, 0));
		prog.push_back(i_type(op_imm, 3'b000, 15, 0, 1));
		prog.push_back(r_type(7'h00, 14, 1, 3'b000, 16));
		prog.push_back(j_type(0, 0));
	endtask

	// expected retire of the instruction at the model pc
	task automatic predict_retire();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [2:0] f3;
		logic [9:0] idx;
		logic [15:0] half;
		logic [3:0] base;
		ins = model_imem[model_pc[imem_depth_log2+1:2]];
		f3 = ins[14:12];
		a = mregs[ins[19:15]];
		b = mregs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		expected = '0;
		expected.pc = model_pc;
		expected.instruction = ins;
		expected.rd = ins[11:7];
		expected_npc = model_pc + 32'd4;
		case (ins[6:0])
			op_lui: begin
				expected.rd_we = 1'b1;
				expected.rd_data = imm_u;
			end
			op_auipc: begin
				expected.rd_we = 1'b1;
				expected.rd_data = model_pc + imm_u;
			end
			op_jal: begin
				expected.rd_we = 1'b1;
				expected.rd_data = model_pc + 32'd4;
				expected_npc = model_pc + imm_j;
			end
			op_jalr: begin
				expected.rd_we = 1'b1;
				expected.rd_data = model_pc + 32'd4;
				expected_npc = (a + imm_i) & ~32'd1;
			end
			op_branch: begin
				if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
					expected_npc = model_pc + imm_b;
				end
			end
			op_load: begin
				addr = a + imm_i;
				idx = addr[9:0];
				half = {mdmem[idx + 10'd1], mdmem[idx]};
				expected.rd_we = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				case (f3)
					3'b000: expected.rd_data = {{24{mdmem[idx][7]}}, mdmem[idx]};
					3'b100: expected.rd_data = {24'b0, mdmem[idx]};
					3'b001: expected.rd_data = {{16{half[15]}}, half};
					3'b101: expected.rd_data = {16'b0, half};
					default: expected.rd_data = {mdmem[idx + 10'd3], mdmem[idx + 10'd2], half};
				endcase
			end
			op_store: begin
				addr = a + imm_s;
				base = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
				expected.mem_we = f3 inside {3'b000, 3'b001, 3'b010};
				expected.mem_addr = {addr[31:2], 2'b00};
				expected.mem_mask = base << addr[1:0];
				expected.mem_wdata = b << (8 * addr[1:0]);
			end
			op_imm, op_reg: begin
				if (ins[6:0] == op_imm) begin
					b = imm_i;
				end
				expected.rd_we = f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
				case (f3)
					3'b000: begin
						if (ins[6:0] == op_reg && ins[31:25] == 7'b0100000) begin
							expected.rd_data = a - b;
						end else begin
							expected.rd_data = a + b;
						end
					end
					3'b010: expected.rd_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: expected.rd_data = a ^ b;
					3'b110: expected.rd_data = a | b;
					default: expected.rd_data = a & b;
				endcase
			end
			default: expected.rd_we = 1'b0;
		endcase
	endtask

	always @(negedge clk) begin
		predict_retire();
	end

	// model steps with each retire
	always @(posedge clk) begin
		if (retire_valid) begin
			if (expected.rd_we && expected.rd != 5'd0) begin
				mregs[expected.rd] <= expected.rd_data;
			end
			for (int lane = 0; lane < 4; lane++) begin
				if (expected.mem_we && expected.mem_mask[lane]) begin
					mdmem[expected.mem_addr[9:0] + 10'(lane)] <= expected.mem_wdata[8*lane +: 8];
				end
			end
			model_pc <= expected_npc;
			retire_count <= retire_count + 1;
		end
	end

	idle_when_stopped: assert property (@(posedge clk) !run |-> !retire_valid)
		else value_error("retire_valid high while run is low");

	first_retire_pc: assert property (@(posedge clk) disable iff (!arst_n)
		(retire_valid && retire_count == 0) |-> retire.pc == 32'd0)
		else value_error($sformatf("first retire at pc %h", $sampled(retire.pc)));

	pc_matches: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> retire.pc == expected.pc)
		else value_error($sformatf("retire pc %h, model pc %h",
			$sampled(retire.pc), $sampled(expected.pc)));

	instruction_matches: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> retire.instruction == expected.instruction)
		else value_error($sformatf("instruction %h, loaded %h",
			$sampled(retire.instruction), $sampled(expected.instruction)));

	rd_we_matches: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> retire.rd_we == expected.rd_we)
		else value_error($sformatf("rd_we %b at pc %h", $sampled(retire.rd_we),
			$sampled(retire.pc)));

	rd_matches: assert property (@(posedge clk) disable iff (!arst_n)
		(retire_valid && expected.rd_we) |->
		(retire.rd == expected.rd && retire.rd_data == expected.rd_data))
		else value_error($sformatf("x%0d = %h at pc %h, model x%0d = %h",
			$sampled(retire.rd), $sampled(retire.rd_data), $sampled(retire.pc),
			$sampled(expected.rd), $sampled(expected.rd_data)));

	mem_we_matches: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> retire.mem_we == expected.mem_we)
		else value_error($sformatf("mem_we %b at pc %h", $sampled(retire.mem_we),
			$sampled(retire.pc)));

	store_matches: assert property (@(posedge clk) disable iff (!arst_n)
		(retire_valid && expected.mem_we) |->
		(retire.mem_addr == expected.mem_addr && retire.mem_mask == expected.mem_mask &&
		retire.mem_wdata == expected.mem_wdata))
		else value_error($sformatf("store %h mask %b data %h, model %h mask %b data %h",
			$sampled(retire.mem_addr), $sampled(retire.mem_mask), $sampled(retire.mem_wdata),
			$sampled(expected.mem_addr), $sampled(expected.mem_mask),
			$sampled(expected.mem_wdata)));

	pc_held_while_stopped: assert property (@(posedge clk) disable iff (!arst_n)
		!run |=> $stable(retire.pc))
		else value_error($sformatf("pc moved to %h while stopped", $sampled(retire.pc)));

	task automatic wait_until_pc(input logic [31:0] target, input int limit);
		int cycles;
		cycles = 0;
		while (model_pc != target && cycles < limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (model_pc != target) begin
			stop_on_failure($sformatf("timeout, pc never reached %h", target));
		end
	endtask

	initial begin
		logic [31:0] halt_pc;
		arst_n = 1'b0;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		model_pc = '0;
		retire_count = 0;
		rng = 32'd76;
		for (int r = 0; r < 32; r++) begin
			mregs[r] = '0;
		end
		build_program();
		halt_pc = 32'(4 * (prog.size() - 1));
		repeat (4) @(posedge clk);
		#1 arst_n = 1'b1;
		// program load while frozen
		foreach (prog[i]) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = imem_depth_log2'(i);
			imem_wdata = prog[i];
			model_imem[i] = prog[i];
		end
		@(posedge clk);
		#1 imem_we = 1'b0;
		run = 1'b1;
		// stop in the arithmetic section for a few cycles
		wait_until_pc(32'd80, 200);
		run = 1'b0;
		repeat (5) @(posedge clk);
		#1 run = 1'b1;
		wait_until_pc(halt_pc, 400);
		repeat (3) @(posedge clk);
		#1 run = 1'b0;
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

/* build.f */
source/rv_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/pc_unit.sv
source/inst_mem.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/rv_core.sv
bench/tb_rv_core.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	input alu_op_e op,
	output logic [xlen-1:0] result,
	output logic zero
);
	logic less;

	// signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {{(xlen-1){1'b0}}, less};
			default: result = a + b;
		endcase
	end

	// beq and bne look at this after a sub
	assign zero = (result == '0);

endmodule

/* source/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;
	import rv_isa_pkg::*;

	// gpr write source, the csr entry of the old mux is gone
	typedef enum logic [1:0] {wb_imm, wb_alu, wb_pc4, wb_load} wb_sel_e;

	typedef enum logic {src_a_rs1, src_a_pc} src_a_e;
	typedef enum logic {src_b_rs2, src_b_imm} src_b_e;

	typedef enum logic [2:0] {npc_seq, npc_beq, npc_bne, npc_jal, npc_jalr} npc_sel_e;

	typedef struct packed {
		logic gpr_write;
		wb_sel_e wb_sel;
		src_a_e alu_src_a;
		src_b_e alu_src_b;
		alu_op_e alu_op;
		logic mem_read;
		logic mem_write;
		logic [3:0] store_mask;
		load_ext_e load_ext;
		npc_sel_e npc_sel;
	} ctrl_word_t;

	// no write anywhere, pc steps by 4
	localparam ctrl_word_t ctrl_nop = '{
		gpr_write: 1'b0,
		wb_sel: wb_alu,
		alu_src_a: src_a_rs1,
		alu_src_b: src_b_rs2,
		alu_op: alu_add,
		mem_read: 1'b0,
		mem_write: 1'b0,
		store_mask: 4'b0000,
		load_ext: ext_w,
		npc_sel: npc_seq
	};

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instruction;
		logic rd_we;
		logic [4:0] rd;
		logic [xlen-1:0] rd_data;
		logic mem_we;
		logic [xlen-1:0] mem_addr;
		logic [3:0] mem_mask;
		logic [xlen-1:0] mem_wdata;
	} retire_t;

endpackage

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem import rv_isa_pkg::*; (
	input logic clk,
	input logic run,
	input logic mem_read,
	input logic mem_write,
	input logic [3:0] store_mask,
	input load_ext_e load_ext,
	input logic [xlen-1:0] addr,
	input logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rdata,
	output logic [xlen-1:0] aligned_addr,
	output logic [3:0] lane_mask,
	output logic [xlen-1:0] lane_wdata
);
	logic [3:0][7:0] mem [2**dmem_depth_log2];
	logic [1:0] offset;
	logic [dmem_depth_log2-1:0] word_idx;
	logic [xlen-1:0] shifted;

	assign aligned_addr = {addr[xlen-1:2], 2'b00};
	assign offset = addr[1:0];
	assign word_idx = addr[dmem_depth_log2+1:2];

	// move mask and data up into the lanes of the offset
	assign lane_mask = mem_write ? 4'(store_mask << offset) : 4'b0000;
	assign lane_wdata = wdata << {offset, 3'b000};

	always_ff @(posedge clk) begin
		if (run) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (lane_mask[lane]) begin
					mem[word_idx][lane] <= lane_wdata[8*lane +: 8];
				end
			end
		end
	end

	// bring the addressed byte down to bit 0
	assign shifted = mem[word_idx] >> {offset, 3'b000};

	always_comb begin
		rdata = '0;
		if (mem_read) begin
			case (load_ext)
				ext_b: rdata = {{24{shifted[7]}}, shifted[7:0]};
				ext_bu: rdata = {24'b0, shifted[7:0]};
				ext_h: rdata = {{16{shifted[15]}}, shifted[15:0]};
				ext_hu: rdata = {16'b0, shifted[15:0]};
				default: rdata = shifted;
			endcase
		end
	end

	// store lanes stay inside the addressed word
	store_in_word: assert property (
		@(posedge clk) (run && mem_write) |->
		($countones(lane_mask) == $countones(store_mask))
	) else $error("store mask %b at offset %0d leaves the word", store_mask, offset);

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input logic [xlen-1:0] instruction,
	output ctrl_word_t ctrl,
	output logic [xlen-1:0] imm,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd
);
	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	imm_type_e imm_type;
	alu_op_e arith_op;
	logic arith_ok;

	assign opcode = opcode_e'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign rd = instruction[11:7];
	assign rs1 = instruction[19:15];
	assign rs2 = instruction[24:20];

	// shared by reg and imm forms, sub only in the reg form
	always_comb begin
		arith_op = alu_add;
		arith_ok = 1'b1;
		case (alu_funct3_e'(funct3))
			f3_add_sub: begin
				if (opcode == op_reg && funct7 == f7_sub) begin
					arith_op = alu_sub;
				end
			end
			f3_slt: arith_op = alu_slt;
			f3_xor: arith_op = alu_xor;
			f3_or: arith_op = alu_or;
			f3_and: arith_op = alu_and;
			// shifts and sltu are not implemented
			default: arith_ok = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = ctrl_nop;
		imm_type = imm_i;
		case (opcode)
			op_lui: begin
				ctrl.gpr_write = 1'b1;
				ctrl.wb_sel = wb_imm;
				imm_type = imm_u;
			end
			op_auipc: begin
				ctrl.gpr_write = 1'b1;
				ctrl.alu_src_a = src_a_pc;
				ctrl.alu_src_b = src_b_imm;
				imm_type = imm_u;
			end
			op_jal: begin
				ctrl.gpr_write = 1'b1;
				ctrl.wb_sel = wb_pc4;
				ctrl.npc_sel = npc_jal;
				imm_type = imm_j;
			end
			op_jalr: begin
				ctrl.gpr_write = 1'b1;
				ctrl.wb_sel = wb_pc4;
				ctrl.npc_sel = npc_jalr;
			end
			op_branch: begin
				ctrl.alu_op = alu_sub;
				imm_type = imm_b;
				if (funct3 == f3_beq) begin
					ctrl.npc_sel = npc_beq;
				end else if (funct3 == f3_bne) begin
					ctrl.npc_sel = npc_bne;
				end
			end
			op_load: begin
				if (funct3 inside {ext_b, ext_h, ext_w, ext_bu, ext_hu}) begin
					ctrl.gpr_write = 1'b1;
					ctrl.wb_sel = wb_load;
					ctrl.alu_src_b = src_b_imm;
					ctrl.mem_read = 1'b1;
					ctrl.load_ext = load_ext_e'(funct3);
				end
			end
			op_store: begin
				ctrl.alu_src_b = src_b_imm;
				ctrl.mem_write = 1'b1;
				imm_type = imm_s;
				// mask for offset 0, data_mem shifts it
				case (funct3)
					f3_sb: ctrl.store_mask = 4'b0001;
					f3_sh: ctrl.store_mask = 4'b0011;
					f3_sw: ctrl.store_mask = 4'b1111;
					default: ctrl.mem_write = 1'b0;
				endcase
			end
			op_imm, op_reg: begin
				if (arith_ok) begin
					ctrl.gpr_write = 1'b1;
					ctrl.alu_op = arith_op;
					if (opcode == op_imm) begin
						ctrl.alu_src_b = src_b_imm;
					end
				end
			end
			default: ctrl = ctrl_nop;
		endcase
	end

	always_comb begin
		case (imm_type)
			imm_s: imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
			imm_b: imm = {{19{instruction[31]}}, instruction[31], instruction[7],
				instruction[30:25], instruction[11:8], 1'b0};
			imm_u: imm = {instruction[31:12], 12'b0};
			imm_j: imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
				instruction[20], instruction[30:21], 1'b0};
			default: imm = {{20{instruction[31]}}, instruction[31:20]};
		endcase
	end

endmodule

/* source/inst_mem.sv */
`timescale 1ns/1ps

module inst_mem import rv_isa_pkg::*; (
	input logic clk,
	input logic imem_we,
	input logic [imem_depth_log2-1:0] imem_addr,
	input logic [xlen-1:0] imem_wdata,
	input logic [xlen-1:0] pc,
	output logic [xlen-1:0] instruction
);
	logic [xlen-1:0] mem [2**imem_depth_log2];

	// loader port, word addressed
	always_ff @(posedge clk) begin
		if (imem_we) begin
			mem[imem_addr] <= imem_wdata;
		end
	end

	// byte pc to word index
	assign instruction = mem[pc[imem_depth_log2+1:2]];

endmodule

/* source/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic run,
	input npc_sel_e npc_sel,
	input logic [xlen-1:0] imm,
	input logic [xlen-1:0] rs1_data,
	input logic zero,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] pc_plus4
);
	logic [xlen-1:0] pc_target;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] pc_next;

	assign pc_plus4 = pc + 32'd4;
	assign pc_target = pc + imm;
	assign jalr_sum = rs1_data + imm;

	// zero comes from rs1 - rs2 in the alu
	always_comb begin
		case (npc_sel)
			npc_beq: pc_next = zero ? pc_target : pc_plus4;
			npc_bne: pc_next = zero ? pc_plus4 : pc_target;
			npc_jal: pc_next = pc_target;
			// bit 0 dropped as the isa requires
			npc_jalr: pc_next = {jalr_sum[xlen-1:1], 1'b0};
			default: pc_next = pc_plus4;
		endcase
	end

	// frozen while the program loads
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc_next;
		end
	end

	// only jalr can break alignment
	pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00
	) else $error("pc %h not word aligned", pc);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic we,
	input logic [4:0] waddr,
	input logic [xlen-1:0] wdata,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data
);
	// no storage for x0
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic imem_we,
	input logic [imem_depth_log2-1:0] imem_addr,
	input logic [xlen-1:0] imem_wdata,
	output logic retire_valid,
	output retire_t retire
);
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] instruction;
	ctrl_word_t ctrl;
	logic [xlen-1:0] imm;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;
	logic zero;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] mem_addr;
	logic [3:0] mem_mask;
	logic [xlen-1:0] mem_wdata;
	logic [xlen-1:0] wb_data;
	logic rd_we;

	pc_unit pc0 (
		.clk, .arst_n, .run,
		.npc_sel(ctrl.npc_sel),
		.imm, .rs1_data, .zero,
		.pc, .pc_plus4
	);

	inst_mem imem0 (
		.clk, .imem_we, .imem_addr, .imem_wdata,
		.pc, .instruction
	);

	decoder dec0 (
		.instruction, .ctrl, .imm,
		.rs1, .rs2, .rd
	);

	// no register write while frozen
	assign rd_we = run && ctrl.gpr_write;

	reg_file gpr0 (
		.clk, .arst_n,
		.we(rd_we), .waddr(rd), .wdata(wb_data),
		.rs1, .rs2, .rs1_data, .rs2_data
	);

	// operand muxes
	assign alu_a = (ctrl.alu_src_a == src_a_pc) ? pc : rs1_data;
	assign alu_b = (ctrl.alu_src_b == src_b_imm) ? imm : rs2_data;

	alu alu0 (
		.a(alu_a), .b(alu_b), .op(ctrl.alu_op),
		.result(alu_result), .zero
	);

	data_mem dmem0 (
		.clk, .run,
		.mem_read(ctrl.mem_read), .mem_write(ctrl.mem_write),
		.store_mask(ctrl.store_mask), .load_ext(ctrl.load_ext),
		.addr(alu_result), .wdata(rs2_data),
		.rdata(load_data), .aligned_addr(mem_addr),
		.lane_mask(mem_mask), .lane_wdata(mem_wdata)
	);

	always_comb begin
		case (ctrl.wb_sel)
			wb_imm: wb_data = imm;
			wb_alu: wb_data = alu_result;
			wb_pc4: wb_data = pc_plus4;
			default: wb_data = load_data;
		endcase
	end

	// one retire per edge while running
	assign retire_valid = run;

	always_comb begin
		retire.pc = pc;
		retire.instruction = instruction;
		retire.rd_we = rd_we;
		retire.rd = rd;
		retire.rd_data = wb_data;
		retire.mem_we = run && ctrl.mem_write;
		retire.mem_addr = mem_addr;
		retire.mem_mask = mem_mask;
		retire.mem_wdata = mem_wdata;
	end

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

	// data and address width
	localparam int xlen = 32;

	// memory depths in words
	localparam int imem_depth_log2 = 8;
	localparam int dmem_depth_log2 = 8;

	// funct fields that pick among forms of one opcode
	localparam logic [6:0] f7_sub = 7'b0100000;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_sb = 3'b000;
	localparam logic [2:0] f3_sh = 3'b001;
	localparam logic [2:0] f3_sw = 3'b010;

	typedef enum logic [6:0] {
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal = 7'b1101111,
		op_jalr = 7'b1100111,
		op_branch = 7'b1100011,
		op_load = 7'b0000011,
		op_store = 7'b0100011,
		op_imm = 7'b0010011,
		op_reg = 7'b0110011
	} opcode_e;

	// funct3 of the register and immediate arithmetic forms
	typedef enum logic [2:0] {
		f3_add_sub = 3'b000,
		f3_slt = 3'b010,
		f3_xor = 3'b100,
		f3_or = 3'b110,
		f3_and = 3'b111
	} alu_funct3_e;

	typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt} alu_op_e;

	// values equal the load funct3
	typedef enum logic [2:0] {
		ext_b = 3'b000,
		ext_h = 3'b001,
		ext_w = 3'b010,
		ext_bu = 3'b100,
		ext_hu = 3'b101
	} load_ext_e;

endpackage
